/* logic/cw_reg_pkg.sv */
package cw_reg_pkg;

   localparam logic [5:0] ADDR_EXTCLK  = 6'd38;  // clock control, storage only
   localparam logic [5:0] ADDR_TRIGSRC = 6'd39;  // external trigger sources
   localparam logic [5:0] ADDR_TRIGMOD = 6'd40;  // trigger module select
   localparam logic [5:0] ADDR_IOROUTE = 6'd55;  // eight routing bytes
   localparam logic [5:0] ADDR_IOREAD  = 6'd59;  // pin sample, read only

   localparam int IOROUTE_BYTES = 8;
   localparam int BYTE_IDX_BITS = $clog2(IOROUTE_BYTES);
   localparam int BYTE_EXTRA    = 5;             // avr enable and power bits
   localparam int BYTE_GPIO     = 6;             // nrst / pdid / pdic controls

   localparam logic [15:0] LEN_SINGLE  = 16'd1;
   localparam logic [15:0] LEN_IOROUTE = 16'(IOROUTE_BYTES);

   typedef struct packed {
      logic gpio_en;     // drive gpio_level when nothing else claims the pin
      logic gpio_level;
      logic tx_oc;       // open-collector tx, pin 3 only
      logic usi_oc;      // open-collector usi out, pin 3 only
      logic usi_in;
      logic usi_out;
      logic rx;
      logic tx;          // bit 0
   } pin_route_t;

   // byte 4 carries the old glitch output bits and is left as plain storage
   typedef logic [IOROUTE_BYTES-1:0][7:0] ioroute_t;

   typedef struct packed {
      logic [4:0] spare;
      logic       power_fast;  // 1 skips the soft-start
      logic       power_off;
      logic       avr_en;
   } extra_t;

   typedef struct packed {
      logic [1:0] spare;
      logic       pdic;
      logic       pdic_en;
      logic       pdid;
      logic       pdid_en;
      logic       nrst;
      logic       nrst_en;
   } gpio_ctl_t;

   typedef struct packed {
      logic [1:0] mode;  // or / and / nand
      logic       io4;
      logic       io3;
      logic       io2;
      logic       io1;
      logic       fpb;
      logic       fpa;
   } trigsrc_t;

   typedef struct packed {
      logic [4:0] spare;
      logic [2:0] sel;
   } trigmod_t;

   localparam logic [7:0] RST_EXTCLK  = 8'h03;
   localparam trigsrc_t   RST_TRIGSRC = 8'h20;      // io4 enabled, or mode
   localparam trigmod_t   RST_TRIGMOD = 8'h00;      // edge trigger
   localparam ioroute_t   RST_IOROUTE = 64'h0201;   // tx on pin 1, rx on pin 2

endpackage

/* logic/cw_pin_pkg.sv */
package cw_pin_pkg;

   localparam int NUM_PINS = 4;
   localparam int USI_PINS = 3;    // pins 1..3 can carry usi
   localparam int OC_PIN   = 2;    // index of pin 3, the open-collector pin

   // combine modes in trigsrc bits 7:6, code 3 yields 0
   localparam logic [1:0] COMB_OR   = 2'b00;
   localparam logic [1:0] COMB_AND  = 2'b01;
   localparam logic [1:0] COMB_NAND = 2'b10;

   // trigger module select, unlisted codes give 0
   localparam logic [2:0] TRIGMOD_EDGE    = 3'd0;
   localparam logic [2:0] TRIGMOD_ADVIO   = 3'd1;
   localparam logic [2:0] TRIGMOD_ANAPAT  = 3'd2;
   localparam logic [2:0] TRIGMOD_DECODED = 3'd3;

   typedef struct packed {
      logic [NUM_PINS-1:0] out;   // bit 0 is pin 1
      logic [NUM_PINS-1:0] oe;
   } pin_drv_t;

   typedef struct packed {
      logic io1;          // rear target io lines
      logic io2;
      logic io3;
      logic io4;
      logic advio;        // advanced io pattern trigger
      logic anapattern;   // analog pattern trigger
      logic decodedio;    // decoded io trigger
   } trig_in_t;

   // soft-start pwm, 2048 cycle period with the switch off for 1400 of them
   localparam int PWM_BITS      = 11;
   localparam int PWM_ON_CYCLES = 1400;
   localparam int SOFT_PERIODS  = 16383;
   localparam int SOFT_CNT_BITS = 14;

endpackage

/* logic/cw_reg_file.sv */
`timescale 1ns/1ps

module cw_reg_file (
   input  logic                 clk_usb,
   input  logic                 reset,
   input  logic [5:0]           reg_address_i,
   input  logic [15:0]          reg_bytecnt_i,
   input  logic [7:0]           reg_datai_i,
   input  logic                 reg_read_i,
   input  logic                 reg_write_i,
   input  logic                 reg_addrvalid_i,
   input  logic [5:0]           reg_hypaddress_i,
   input  logic [3:0]           ioread_i,
   output logic [7:0]           reg_datao_o,
   output logic [15:0]          reg_hyplen_o,
   output cw_reg_pkg::trigsrc_t trigsrc_o,
   output cw_reg_pkg::trigmod_t trigmod_o,
   output cw_reg_pkg::ioroute_t ioroute_o,
   output logic [7:0]           extclk_o
);
   import cw_reg_pkg::*;

   logic [BYTE_IDX_BITS-1:0] byte_idx;   // routing byte under access
   logic [7:0]               rd_next;    // read mux before the output flop
   logic [7:0]               rd_data;
   logic                     rd_valid;

   // byte length of each register as the host sees it, 0 for unknown
   function automatic logic [15:0] reg_len(input logic [5:0] addr);
      case (addr)
         ADDR_EXTCLK,
         ADDR_TRIGSRC,
         ADDR_TRIGMOD,
         ADDR_IOREAD:  reg_len = LEN_SINGLE;
         ADDR_IOROUTE: reg_len = LEN_IOROUTE;
         default:      reg_len = '0;
      endcase
   endfunction

   assign byte_idx = reg_bytecnt_i[BYTE_IDX_BITS-1:0];

   assign reg_hyplen_o = reg_len(reg_hypaddress_i);   // pure lookup, no clock

   // host writes land on the edge that samples reg_write_i
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         extclk_o  <= RST_EXTCLK;
         trigsrc_o <= RST_TRIGSRC;
         trigmod_o <= RST_TRIGMOD;
         ioroute_o <= RST_IOROUTE;
      end else if (reg_write_i) begin
         case (reg_address_i)
            ADDR_EXTCLK:  extclk_o            <= reg_datai_i;
            ADDR_TRIGSRC: trigsrc_o           <= reg_datai_i;
            ADDR_TRIGMOD: trigmod_o           <= reg_datai_i;
            ADDR_IOROUTE: ioroute_o[byte_idx] <= reg_datai_i;   // bytecnt picks the byte
            default:      ;                                     // ioread and others ignore writes
         endcase
      end
   end

   always_comb begin
      case (reg_address_i)
         ADDR_EXTCLK:  rd_next = extclk_o;
         ADDR_TRIGSRC: rd_next = trigsrc_o;
         ADDR_TRIGMOD: rd_next = trigmod_o;
         ADDR_IOROUTE: rd_next = ioroute_o[byte_idx];
         ADDR_IOREAD:  rd_next = {4'b0000, ioread_i};   // sample taken a cycle earlier
         default:      rd_next = '0;
      endcase
   end

   always_ff @(posedge clk_usb) begin
      if (reg_read_i) begin
         rd_data <= rd_next;   // held between reads
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= reg_addrvalid_i && (reg_len(reg_address_i) != '0);   // unknown address stays 0
      end
   end

   assign reg_datao_o = rd_valid ? rd_data : '0;

   // the host never addresses past the last routing byte
   a_ioroute_bytecnt: assert property (@(posedge clk_usb) disable iff (reset)
      (reg_write_i && reg_address_i == ADDR_IOROUTE) |-> (reg_bytecnt_i < IOROUTE_BYTES))
      else $error("ioroute write with bytecnt %0d", reg_bytecnt_i);

endmodule

/* logic/cw_trigger_route.sv */
`timescale 1ns/1ps

module cw_trigger_route (
   input  cw_reg_pkg::trigsrc_t trigsrc_i,
   input  cw_reg_pkg::trigmod_t trigmod_i,
   input  cw_pin_pkg::trig_in_t trig_i,
   output logic                 trigger_ext_o,
   output logic                 trigger_o
);
   import cw_pin_pkg::*;

   logic [5:0] src;        // fpa, fpb, io1..io4 from bit 0 up
   logic [5:0] en;         // matching enables from trigsrc
   logic       trig_or;
   logic       trig_and;

   // front panel feedback no longer exists so fpa and fpb read low
   assign src = {trig_i.io4, trig_i.io3, trig_i.io2, trig_i.io1, 1'b0, 1'b0};

   assign en = {trigsrc_i.io4, trigsrc_i.io3, trigsrc_i.io2,
                trigsrc_i.io1, trigsrc_i.fpb, trigsrc_i.fpa};

   assign trig_or  = |(src & en);    // any enabled source high
   assign trig_and = &(src | ~en);   // disabled sources count as 1

   always_comb begin
      case (trigsrc_i.mode)
         COMB_OR:   trigger_ext_o = trig_or;
         COMB_AND:  trigger_ext_o = trig_and;
         COMB_NAND: trigger_ext_o = ~trig_and;
         default:   trigger_ext_o = 1'b0;      // spare encoding
      endcase
   end

   // module select picks the combined edge trigger or an advanced one
   always_comb begin
      case (trigmod_i.sel)
         TRIGMOD_EDGE:    trigger_o = trigger_ext_o;
         TRIGMOD_ADVIO:   trigger_o = trig_i.advio;
         TRIGMOD_ANAPAT:  trigger_o = trig_i.anapattern;
         TRIGMOD_DECODED: trigger_o = trig_i.decodedio;
         default:         trigger_o = 1'b0;
      endcase
   end

endmodule

/* logic/cw_target_io.sv */
`timescale 1ns/1ps

module cw_target_io (
   input  logic                  clk_usb,
   input  logic                  reset,
   input  cw_reg_pkg::ioroute_t  ioroute_i,
   input  logic                  pins_off_i,
   input  logic                  uart_tx_i,
   input  logic                  usi_out_i,
   input  logic [3:0]            pin_in_i,
   output cw_pin_pkg::pin_drv_t  pin_drv_o,
   output logic                  uart_rx_o,
   output logic                  usi_in_o,
   output logic                  enable_avrprog_o,
   output cw_reg_pkg::gpio_ctl_t gpio_o,
   output logic [3:0]            ioread_o
);
   import cw_reg_pkg::*;
   import cw_pin_pkg::*;

   pin_route_t [NUM_PINS-1:0] route;   // one routing byte per target pin
   extra_t                    extra;

   assign route = ioroute_i[NUM_PINS-1:0];
   assign extra = ioroute_i[BYTE_EXTRA];

   assign enable_avrprog_o = extra.avr_en;
   assign gpio_o           = ioroute_i[BYTE_GPIO];

   // drive priority per pin is tx, usi out, open-collector, gpio
   always_comb begin
      pin_drv_o = '0;
      for (int p = 0; p < NUM_PINS; p++) begin
         if (route[p].tx) begin
            pin_drv_o.out[p] = uart_tx_i;
            pin_drv_o.oe[p]  = 1'b1;
         end else if (route[p].usi_out && p < USI_PINS) begin
            pin_drv_o.out[p] = usi_out_i;
            pin_drv_o.oe[p]  = 1'b1;
         end else if (route[p].usi_oc && p == OC_PIN) begin
            pin_drv_o.oe[p]  = ~usi_out_i;   // pull low only, release when high
         end else if (route[p].tx_oc && p == OC_PIN) begin
            pin_drv_o.oe[p]  = ~uart_tx_i;
         end else if (route[p].gpio_en) begin
            pin_drv_o.out[p] = route[p].gpio_level;
            pin_drv_o.oe[p]  = 1'b1;
         end
      end
      if (pins_off_i) begin
         pin_drv_o.oe = '0;                  // target unpowered so no pin is driven
      end
   end

   // lowest pin wins, walk down so it is assigned last
   always_comb begin
      uart_rx_o = 1'b1;                      // idle level with no rx pin
      usi_in_o  = 1'b1;
      for (int p = NUM_PINS - 1; p >= 0; p--) begin
         if (route[p].rx) begin
            uart_rx_o = pin_in_i[p];
         end
         if (route[p].usi_in && p < USI_PINS) begin
            usi_in_o = pin_in_i[p];
         end
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ioread_o <= '0;
      end else begin
         ioread_o <= pin_in_i & pin_drv_o.oe;   // undriven pins read back 0
      end
   end

endmodule

/* logic/cw_target_power.sv */
`timescale 1ns/1ps

module cw_target_power (
   input  logic clk_usb,
   input  logic reset,
   input  logic power_off_i,
   input  logic power_fast_i,
   output logic pins_off_o,
   output logic targetpower_off_o
);
   import cw_pin_pkg::*;

   logic                     off_q;       // registered power-off request
   logic                     off_prev;
   logic                     soft_on;     // set by the off to on change
   logic                     pwm_active;  // pwm drives the switch
   logic [PWM_BITS-1:0]      pwm_cnt;     // free running, one period per wrap
   logic [SOFT_CNT_BITS-1:0] soft_cnt;    // periods done in this soft-start
   logic                     pwm_high;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         off_q    <= 1'b0;
         off_prev <= 1'b0;
      end else begin
         off_q    <= power_off_i;
         off_prev <= off_q;
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         soft_on <= 1'b0;
      end else if (!off_q && off_prev) begin
         soft_on <= 1'b1;                 // power just switched on
      end else if (off_q) begin
         soft_on <= 1'b0;                 // off request aborts the ramp
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         pwm_cnt <= '0;
      end else begin
         pwm_cnt <= pwm_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset || !soft_on) begin
         soft_cnt   <= '0;
         pwm_active <= 1'b0;
      end else if (soft_cnt == SOFT_CNT_BITS'(SOFT_PERIODS)) begin
         pwm_active <= 1'b0;              // ramp finished, stay on
      end else if (pwm_cnt == '0) begin
         soft_cnt   <= soft_cnt + 1'b1;
         pwm_active <= 1'b1;              // start of each period
      end
   end

   assign pwm_high = pwm_cnt < PWM_BITS'(PWM_ON_CYCLES);

   // off request wins at once, fast mode skips the pwm
   assign targetpower_off_o = off_q | (pwm_active & ~power_fast_i & pwm_high);
   assign pins_off_o        = off_q;

endmodule

/* logic/cw_io_top.sv */
`timescale 1ns/1ps

module cw_io_top (
   input  logic                  clk_usb,
   input  logic                  reset,
   input  logic [5:0]            reg_address_i,
   input  logic [15:0]           reg_bytecnt_i,
   input  logic [7:0]            reg_datai_i,
   input  logic                  reg_read_i,
   input  logic                  reg_write_i,
   input  logic                  reg_addrvalid_i,
   input  logic [5:0]            reg_hypaddress_i,
   input  cw_pin_pkg::trig_in_t  trig_i,
   input  logic                  uart_tx_i,
   input  logic                  usi_out_i,
   input  logic [3:0]            pin_in_i,
   output logic [7:0]            reg_datao_o,
   output logic [15:0]           reg_hyplen_o,
   output logic                  trigger_o,
   output logic                  trigger_ext_o,
   output cw_pin_pkg::pin_drv_t  pin_drv_o,
   output logic                  uart_rx_o,
   output logic                  usi_in_o,
   output logic                  enable_avrprog_o,
   output cw_reg_pkg::gpio_ctl_t gpio_o,
   output logic                  targetpower_off_o
);
   import cw_reg_pkg::*;

   trigsrc_t   trigsrc;
   trigmod_t   trigmod;
   ioroute_t   ioroute;
   extra_t     extra;     // power bits for the soft-start block
   logic       pins_off;
   logic [3:0] ioread;

   assign extra = ioroute[BYTE_EXTRA];

   cw_reg_file u_reg_file (
      .clk_usb          (clk_usb),
      .reset            (reset),
      .reg_address_i    (reg_address_i),
      .reg_bytecnt_i    (reg_bytecnt_i),
      .reg_datai_i      (reg_datai_i),
      .reg_read_i       (reg_read_i),
      .reg_write_i      (reg_write_i),
      .reg_addrvalid_i  (reg_addrvalid_i),
      .reg_hypaddress_i (reg_hypaddress_i),
      .ioread_i         (ioread),
      .reg_datao_o      (reg_datao_o),
      .reg_hyplen_o     (reg_hyplen_o),
      .trigsrc_o        (trigsrc),
      .trigmod_o        (trigmod),
      .ioroute_o        (ioroute),
      .extclk_o         ()                // clock muxing removed, register only
   );

   cw_trigger_route u_trigger_route (
      .trigsrc_i     (trigsrc),
      .trigmod_i     (trigmod),
      .trig_i        (trig_i),
      .trigger_ext_o (trigger_ext_o),
      .trigger_o     (trigger_o)
   );

   cw_target_io u_target_io (
      .clk_usb          (clk_usb),
      .reset            (reset),
      .ioroute_i        (ioroute),
      .pins_off_i       (pins_off),
      .uart_tx_i        (uart_tx_i),
      .usi_out_i        (usi_out_i),
      .pin_in_i         (pin_in_i),
      .pin_drv_o        (pin_drv_o),
      .uart_rx_o        (uart_rx_o),
      .usi_in_o         (usi_in_o),
      .enable_avrprog_o (enable_avrprog_o),
      .gpio_o           (gpio_o),
      .ioread_o         (ioread)
   );

   cw_target_power u_target_power (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .power_off_i       (extra.power_off),
      .power_fast_i      (extra.power_fast),
      .pins_off_o        (pins_off),
      .targetpower_off_o (targetpower_off_o)
   );

endmodule

/* dv/cw_io_checker.sv */
`timescale 1ns/1ps

module cw_io_checker (
   input  logic                  clk_usb,
   input  logic                  reset,
   input  int                    phase_i,       // behavior being driven by the tb
   input  logic [7:0]            datao_exp_i,
   input  logic [7:0]            datao_act_i,
   input  logic [15:0]           hyplen_exp_i,
   input  logic [15:0]           hyplen_act_i,
   input  logic [1:0]            trig_exp_i,    // {trigger, trigger_ext}
   input  logic [1:0]            trig_act_i,
   input  cw_pin_pkg::pin_drv_t  drv_exp_i,
   input  cw_pin_pkg::pin_drv_t  drv_act_i,
   input  logic [1:0]            rx_exp_i,      // {usi_in, uart_rx}
   input  logic [1:0]            rx_act_i,
   input  cw_reg_pkg::gpio_ctl_t gpio_exp_i,
   input  cw_reg_pkg::gpio_ctl_t gpio_act_i,
   input  logic                  avr_exp_i,
   input  logic                  avr_act_i,
   input  logic                  power_exp_i,
   input  logic                  power_act_i
);

   int check_count = 0;
   int error_count = 0;

   function automatic string phase_name(input int ph);
      case (ph)
         1:       return "register readback";
         2:       return "trigger combine";
         3:       return "pin drive";
         4:       return "receive routing";
         5:       return "power control";
         6:       return "gpio outputs";
         default: return "idle";
      endcase
   endfunction

   task automatic compare(input string what, input logic [15:0] exp, input logic [15:0] act);
      check_count++;
      if (exp !== act) begin
         error_count++;
         $display("Fail %s / %s: expected 'h%0h actual 'h%0h at %0t",
                  phase_name(phase_i), what, exp, act, $time);
      end
   endtask

   // mid-cycle sample, inputs moved 1 ns after the rising edge
   always @(negedge clk_usb) begin
      if (!reset) begin
         compare("reg_datao", 16'(datao_exp_i), 16'(datao_act_i));
         compare("reg_hyplen", hyplen_exp_i, hyplen_act_i);
         compare("trigger_ext", 16'(trig_exp_i[0]), 16'(trig_act_i[0]));
         compare("trigger", 16'(trig_exp_i[1]), 16'(trig_act_i[1]));
         compare("pin_drv", 16'(drv_exp_i), 16'(drv_act_i));
         compare("uart_rx", 16'(rx_exp_i[0]), 16'(rx_act_i[0]));
         compare("usi_in", 16'(rx_exp_i[1]), 16'(rx_act_i[1]));
         compare("gpio", 16'(gpio_exp_i), 16'(gpio_act_i));
         compare("enable_avrprog", 16'(avr_exp_i), 16'(avr_act_i));
         compare("targetpower_off", 16'(power_exp_i), 16'(power_act_i));
      end
   end

endmodule

/* dv/tb_cw_io.sv */
`timescale 1ns/1ps

module tb_cw_io;
   import cw_reg_pkg::*;
   import cw_pin_pkg::*;

   localparam int WAIT_LIMIT = 3000;   // longer than one pwm period

   logic        clk_usb = 1'b0;
   logic        reset;
   logic [5:0]  reg_address_i;
   logic [15:0] reg_bytecnt_i;
   logic [7:0]  reg_datai_i;
   logic        reg_read_i;
   logic        reg_write_i;
   logic        reg_addrvalid_i;
   logic [5:0]  reg_hypaddress_i;
   trig_in_t    trig_i;
   logic        uart_tx_i;
   logic        usi_out_i;
   logic [3:0]  pin_in_i;
   logic [7:0]  reg_datao_o;
   logic [15:0] reg_hyplen_o;
   logic        trigger_o;
   logic        trigger_ext_o;
   pin_drv_t    pin_drv_o;
   logic        uart_rx_o;
   logic        usi_in_o;
   logic        enable_avrprog_o;
   gpio_ctl_t   gpio_o;
   logic        targetpower_off_o;

   // reference model state
   logic [7:0]  extclk_m;
   trigsrc_t    trigsrc_m;
   trigmod_t    trigmod_m;
   ioroute_t    ioroute_m;
   extra_t      extra_m;
   logic [7:0]  rd_data_m = 8'h00;
   logic        rd_valid_m;
   logic [3:0]  ioread_m;
   logic        off_q_m;
   logic        off_prev_m;
   logic        soft_m;          // soft-start armed
   logic        ramp_m;          // pwm periods running
   logic [10:0] period_cnt_m;    // free running since reset
   logic [13:0] periods_m;

   logic [7:0]  datao_exp;
   logic [15:0] hyplen_exp;
   logic        ext_exp;
   logic        sel_exp;
   pin_drv_t    drv_exp;
   logic [1:0]  rx_exp;
   logic        power_exp;

   int          phase;
   int          timeouts;
   logic [31:0] rnd;

   always #5 clk_usb = ~clk_usb;

   cw_io_top uut (
      .clk_usb (clk_usb), .reset (reset),
      .reg_address_i (reg_address_i), .reg_bytecnt_i (reg_bytecnt_i),
      .reg_datai_i (reg_datai_i), .reg_read_i (reg_read_i), .reg_write_i (reg_write_i),
      .reg_addrvalid_i (reg_addrvalid_i), .reg_hypaddress_i (reg_hypaddress_i),
      .trig_i (trig_i), .uart_tx_i (uart_tx_i), .usi_out_i (usi_out_i), .pin_in_i (pin_in_i),
      .reg_datao_o (reg_datao_o), .reg_hyplen_o (reg_hyplen_o), .trigger_o (trigger_o),
      .trigger_ext_o (trigger_ext_o), .pin_drv_o (pin_drv_o), .uart_rx_o (uart_rx_o),
      .usi_in_o (usi_in_o), .enable_avrprog_o (enable_avrprog_o), .gpio_o (gpio_o),
      .targetpower_off_o (targetpower_off_o)
   );

   cw_io_checker u_checker (
      .clk_usb (clk_usb), .reset (reset), .phase_i (phase),
      .datao_exp_i (datao_exp), .datao_act_i (reg_datao_o),
      .hyplen_exp_i (hyplen_exp), .hyplen_act_i (reg_hyplen_o),
      .trig_exp_i ({sel_exp, ext_exp}), .trig_act_i ({trigger_o, trigger_ext_o}),
      .drv_exp_i (drv_exp), .drv_act_i (pin_drv_o),
      .rx_exp_i (rx_exp), .rx_act_i ({usi_in_o, uart_rx_o}),
      .gpio_exp_i (ioroute_m[BYTE_GPIO]), .gpio_act_i (gpio_o),
      .avr_exp_i (extra_m.avr_en), .avr_act_i (enable_avrprog_o),
      .power_exp_i (power_exp), .power_act_i (targetpower_off_o)
   );

   function automatic logic [15:0] host_len(input logic [5:0] addr);
      if (addr == ADDR_IOROUTE) return 16'd8;
      if (addr == ADDR_EXTCLK || addr == ADDR_TRIGSRC || addr == ADDR_TRIGMOD ||
          addr == ADDR_IOREAD) return 16'd1;
      return 16'd0;
   endfunction

   function automatic logic ext_trigger(input trigsrc_t s, input trig_in_t t);
      logic [5:0] lines;
      logic       any_hi;
      logic       all_hi;
      lines  = {t.io4, t.io3, t.io2, t.io1, 2'b00};   // front panel lines read low
      any_hi = 1'b0;
      all_hi = 1'b1;
      for (int i = 0; i < 6; i++) begin
         if (s[i]) begin
            any_hi = any_hi | lines[i];
            all_hi = all_hi & lines[i];
         end
      end
      case (s.mode)
         COMB_OR:   return any_hi;
         COMB_AND:  return all_hi;
         COMB_NAND: return ~all_hi;
         default:   return 1'b0;
      endcase
   endfunction

   function automatic pin_drv_t drive_pins(input ioroute_t r, input logic tx, input logic usi,
                                           input logic off);
      pin_route_t b;
      pin_drv_t   d;
      d = '0;
      for (int p = 0; p < 4; p++) begin
         b = r[p];
         if (b.tx) begin
            d.out[p] = tx;
            d.oe[p]  = 1'b1;
         end else if (b.usi_out && p != 3) begin
            d.out[p] = usi;
            d.oe[p]  = 1'b1;
         end else if (p == 2 && (b.usi_oc || b.tx_oc)) begin
            d.oe[p]  = b.usi_oc ? ~usi : ~tx;           // pin 3 only pulls low
         end else if (b.gpio_en) begin
            d.out[p] = b.gpio_level;
            d.oe[p]  = 1'b1;
         end
      end
      if (off) begin
         d.oe = '0;
      end
      return d;
   endfunction

   function automatic logic [1:0] receive_lines(input ioroute_t r, input logic [3:0] pins);
      pin_route_t b;
      logic       rx;
      logic       usi;
      logic       rx_found;
      logic       usi_found;
      rx        = 1'b1;
      usi       = 1'b1;
      rx_found  = 1'b0;
      usi_found = 1'b0;
      for (int p = 0; p < 4; p++) begin
         b = r[p];
         if (b.rx && !rx_found) begin
            rx       = pins[p];
            rx_found = 1'b1;
         end
         if (b.usi_in && p < 3 && !usi_found) begin
            usi       = pins[p];
            usi_found = 1'b1;
         end
      end
      return {usi, rx};
   endfunction

   function automatic logic [5:0] pick_addr(input logic [2:0] sel, input logic [5:0] any);
      case (sel)
         3'd0:       return ADDR_EXTCLK;
         3'd1:       return ADDR_TRIGSRC;
         3'd2:       return ADDR_TRIGMOD;
         3'd3, 3'd4: return ADDR_IOROUTE;
         3'd5:       return ADDR_IOREAD;
         default:    return any;           // mostly unmapped addresses
      endcase
   endfunction

   always_comb begin
      extra_m    = ioroute_m[BYTE_EXTRA];
      hyplen_exp = host_len(reg_hypaddress_i);
      ext_exp    = ext_trigger(trigsrc_m, trig_i);
      case (trigmod_m.sel)
         TRIGMOD_EDGE:    sel_exp = ext_exp;
         TRIGMOD_ADVIO:   sel_exp = trig_i.advio;
         TRIGMOD_ANAPAT:  sel_exp = trig_i.anapattern;
         TRIGMOD_DECODED: sel_exp = trig_i.decodedio;
         default:         sel_exp = 1'b0;
      endcase
      drv_exp   = drive_pins(ioroute_m, uart_tx_i, usi_out_i, off_q_m);
      rx_exp    = receive_lines(ioroute_m, pin_in_i);
      datao_exp = rd_valid_m ? rd_data_m : 8'h00;
      power_exp = off_q_m | (ramp_m & ~extra_m.power_fast &
                             (period_cnt_m < 11'(PWM_ON_CYCLES)));   // high part of period
   end

   always @(posedge clk_usb) begin
      if (reset) begin
         extclk_m     <= RST_EXTCLK;
         trigsrc_m    <= RST_TRIGSRC;
         trigmod_m    <= RST_TRIGMOD;
         ioroute_m    <= RST_IOROUTE;
         rd_valid_m   <= 1'b0;
         ioread_m     <= '0;
         off_q_m      <= 1'b0;
         off_prev_m   <= 1'b0;
         soft_m       <= 1'b0;
         ramp_m       <= 1'b0;
         period_cnt_m <= '0;
         periods_m    <= '0;
      end else begin
         if (reg_write_i) begin
            case (reg_address_i)
               ADDR_EXTCLK:  extclk_m                       <= reg_datai_i;
               ADDR_TRIGSRC: trigsrc_m                      <= reg_datai_i;
               ADDR_TRIGMOD: trigmod_m                      <= reg_datai_i;
               ADDR_IOROUTE: ioroute_m[reg_bytecnt_i[2:0]] <= reg_datai_i;
               default:      ;
            endcase
         end
         if (reg_read_i) begin
            case (reg_address_i)
               ADDR_EXTCLK:  rd_data_m <= extclk_m;
               ADDR_TRIGSRC: rd_data_m <= trigsrc_m;
               ADDR_TRIGMOD: rd_data_m <= trigmod_m;
               ADDR_IOROUTE: rd_data_m <= ioroute_m[reg_bytecnt_i[2:0]];
               ADDR_IOREAD:  rd_data_m <= {4'b0000, ioread_m};   // last cycle's sample
               default:      rd_data_m <= 8'h00;
            endcase
         end
         rd_valid_m   <= reg_addrvalid_i && host_len(reg_address_i) != 16'd0;
         ioread_m     <= pin_in_i & drv_exp.oe;
         off_q_m      <= extra_m.power_off;
         off_prev_m   <= off_q_m;
         period_cnt_m <= period_cnt_m + 11'd1;
         if (off_q_m) begin
            soft_m <= 1'b0;
         end else if (off_prev_m) begin
            soft_m <= 1'b1;                     // power just came on
         end
         if (!soft_m) begin
            periods_m <= '0;
            ramp_m    <= 1'b0;
         end else if (periods_m == 14'(SOFT_PERIODS)) begin
            ramp_m    <= 1'b0;
         end else if (period_cnt_m == '0) begin
            periods_m <= periods_m + 14'd1;
            ramp_m    <= 1'b1;
         end
      end
   end

   task automatic next_cycle();
      logic [31:0] r;
      @(posedge clk_usb);
      #1;
      r                = $urandom;
      trig_i           = r[6:0];
      uart_tx_i        = r[7];
      usi_out_i        = r[8];
      pin_in_i         = r[12:9];
      reg_hypaddress_i = r[18:13];
   endtask

   task automatic write_reg(input logic [5:0] addr, input logic [2:0] byte_sel,
                            input logic [7:0] data);
      reg_address_i = addr;
      reg_bytecnt_i = {13'd0, byte_sel};
      reg_datai_i   = data;
      reg_write_i   = 1'b1;
      next_cycle();
      reg_write_i   = 1'b0;
   endtask

   task automatic read_reg(input logic [5:0] addr, input logic [2:0] byte_sel);
      reg_address_i   = addr;
      reg_bytecnt_i   = {13'd0, byte_sel};
      reg_read_i      = 1'b1;
      reg_addrvalid_i = 1'b1;
      next_cycle();
      reg_read_i      = 1'b0;
      reg_addrvalid_i = 1'b0;
   endtask

   task automatic wait_power(input logic level, input string what);
      int   n;
      logic done;
      n    = 0;
      done = 1'b0;
      while (!done && n < WAIT_LIMIT) begin
         @(negedge clk_usb);
         done = (targetpower_off_o === level);
         next_cycle();
         n++;
      end
      if (!done) begin
         timeouts++;
         $display("targetpower_off_o never reached %0b while waiting for %s", level, what);
      end
   endtask

   initial begin
      void'($urandom(21062));
      reset            = 1'b1;
      reg_address_i    = '0;
      reg_bytecnt_i    = '0;
      reg_datai_i      = '0;
      reg_read_i       = 1'b0;
      reg_write_i      = 1'b0;
      reg_addrvalid_i  = 1'b0;
      reg_hypaddress_i = '0;
      trig_i           = '0;
      uart_tx_i        = 1'b0;
      usi_out_i        = 1'b0;
      pin_in_i         = '0;
      phase            = 0;
      timeouts         = 0;
      repeat (4) @(posedge clk_usb);
      #1;
      reset = 1'b0;

      phase = 1;
      repeat (300) begin
         rnd = $urandom;
         write_reg(pick_addr(rnd[2:0], rnd[29:24]), rnd[10:8], rnd[23:16]);
         read_reg(pick_addr(rnd[2:0], rnd[29:24]), rnd[10:8]);
      end

      phase = 2;
      repeat (150) begin
         rnd = $urandom;
         write_reg(ADDR_TRIGSRC, 3'd0, rnd[7:0]);
         write_reg(ADDR_TRIGMOD, 3'd0, rnd[15:8]);
         repeat (4) next_cycle();              // random trigger lines each cycle
      end

      phase = 3;
      repeat (200) begin
         rnd = $urandom;
         write_reg(ADDR_IOROUTE, rnd[2] ? {1'b0, rnd[1:0]} : 3'd5, rnd[15:8]);
         repeat (2) next_cycle();
      end

      phase = 4;
      repeat (200) begin
         rnd = $urandom;
         write_reg(ADDR_IOROUTE, {1'b0, rnd[1:0]}, rnd[15:8]);
         read_reg(ADDR_IOREAD, 3'd0);
         read_reg(ADDR_IOREAD, 3'd0);
      end

      phase = 5;
      write_reg(ADDR_IOROUTE, 3'd5, 8'h06);    // off, fast
      repeat (4) next_cycle();
      write_reg(ADDR_IOROUTE, 3'd5, 8'h04);    // on, fast
      repeat (20) next_cycle();
      write_reg(ADDR_IOROUTE, 3'd5, 8'h02);    // off, slow
      repeat (4) next_cycle();
      write_reg(ADDR_IOROUTE, 3'd5, 8'h00);    // on, soft-start begins
      repeat (4) begin
         wait_power(1'b1, "the switch-off part of a pwm period");
         wait_power(1'b0, "the switch-on part of a pwm period");
      end
      repeat (700) next_cycle();
      write_reg(ADDR_IOROUTE, 3'd5, 8'h02);    // abort mid ramp
      repeat (4) next_cycle();
      write_reg(ADDR_IOROUTE, 3'd5, 8'h04);
      repeat (2100) next_cycle();

      phase = 6;
      repeat (100) begin
         rnd = $urandom;
         write_reg(ADDR_IOROUTE, 3'd6, rnd[7:0]);
         write_reg(ADDR_IOROUTE, 3'd5, rnd[15:8]);
      end
      repeat (5) next_cycle();

      $display("checks %0d, errors %0d, timeouts %0d",
               u_checker.check_count, u_checker.error_count, timeouts);
      if (u_checker.error_count == 0 && timeouts == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* src.f */
logic/cw_reg_pkg.sv
logic/cw_pin_pkg.sv
logic/cw_reg_file.sv
logic/cw_trigger_route.sv
logic/cw_target_io.sv
logic/cw_target_power.sv
logic/cw_io_top.sv
dv/cw_io_checker.sv
dv/tb_cw_io.sv

/* run.sh */
#!/bin/bash
# build and run the testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_cw_io -o tb_cw_io
./obj_dir/tb_cw_io | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
   exit 1
fi
exit 0
